/* src/ilm_pkg.sv */
// ILM ECC package holding the memory geometry, the APB register map and the SECDED codeword.
`default_nettype none

package ilm_pkg;

	localparam int ilm_aw = 9;   // 512 words.
	localparam int ilm_dw = 32;
	localparam int ilm_cw = 39;  // data + hamming + overall parity.
	localparam int ilm_pw = 6;
	localparam int apb_aw = 16;
	localparam int cnt_w  = 16;  // corrected error counter width.

	// paddr[12] set selects the register window.
	localparam int reg_sel_bit = 12;

	localparam logic [reg_sel_bit-1:0] reg_inj_data  = 12'h000;
	localparam logic [reg_sel_bit-1:0] reg_inj_check = 12'h004;
	localparam logic [reg_sel_bit-1:0] reg_corr_cnt  = 12'h008;
	localparam logic [reg_sel_bit-1:0] reg_ue_stat   = 12'h00C;

	// raw bit n is hamming position n, position 0 carries the overall parity.
	// check bits sit at the power of two positions, data fills the rest.
	typedef union packed {
		logic [ilm_cw-1:0] raw;
		struct packed {
			logic [5:0]  d31_26;  // positions 38..33.
			logic        c32;
			logic [14:0] d25_11;  // positions 31..17.
			logic        c16;
			logic [6:0]  d10_4;   // positions 15..9.
			logic        c8;
			logic [2:0]  d3_1;    // positions 7..5.
			logic        c4;
			logic        d0;      // position 3.
			logic        c2;
			logic        c1;
			logic        par;
		} fields;
	} ilm_codeword_u;

endpackage

`default_nettype wire

/* src/ilm_ram_if.sv */
// ILM RAM port bundle between the APB slave and the ECC RAM.
`timescale 1ns/100ps
`default_nettype none

interface ilm_ram_if;

	logic                       cs;     // one cycle pulse per access.
	logic                       we;
	logic [ilm_pkg::ilm_aw-1:0] addr;
	ilm_pkg::ilm_codeword_u     wdata;
	ilm_pkg::ilm_codeword_u     rdata;  // valid the cycle after a read cs.

	// the decoder taps rdata straight off the bundle.
	modport master (
		output cs,
		output we,
		output addr,
		output wdata
	);

	modport ram (
		input  cs,
		input  we,
		input  addr,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* src/ilm_apb_slave.sv */
// ILM APB slave that encodes SECDED writes, sequences reads and keeps the ECC status registers.
`timescale 1ns/100ps
`default_nettype none

module ilm_apb_slave (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         psel,
	input  wire                         penable,
	input  wire                         pwrite,
	input  wire [ilm_pkg::apb_aw-1:0]   paddr,
	input  wire [ilm_pkg::ilm_dw-1:0]   pwdata,
	output logic [ilm_pkg::ilm_dw-1:0]  prdata,
	output logic                        pready,
	output logic                        pslverr,
	ilm_ram_if.master                   ram,
	input  wire [ilm_pkg::ilm_dw-1:0]   rdata_fix,
	input  wire                         corr_err,
	input  wire                         uncorr_err
);

	logic                              rd_pend;  // the single wait state of a memory read.
	logic                              access;
	logic                              mem_sel;
	logic                              aligned;
	logic                              mem_wr;
	logic                              mem_rd;
	logic                              reg_wr;
	logic [ilm_pkg::reg_sel_bit-1:0]   reg_off;
	logic [ilm_pkg::ilm_aw-1:0]        word_addr;
	logic [ilm_pkg::ilm_dw-1:0]        inj_data;
	logic [ilm_pkg::ilm_pw:0]          inj_check;
	logic [ilm_pkg::cnt_w-1:0]         corr_cnt;
	logic                              ue_flag;
	logic [ilm_pkg::ilm_aw-1:0]        ue_addr;
	logic [ilm_pkg::ilm_dw-1:0]        reg_rdata;
	logic [ilm_pkg::ilm_pw-1:0]        chk;
	ilm_pkg::ilm_codeword_u            enc;
	ilm_pkg::ilm_codeword_u            inj;

	// scatter data and check bits into their hamming positions.
	// c[ilm_pw] is the overall parity bit.
	function automatic ilm_pkg::ilm_codeword_u pack_cw(
		input logic [ilm_pkg::ilm_dw-1:0] d,
		input logic [ilm_pkg::ilm_pw:0]   c
	);
		ilm_pkg::ilm_codeword_u cw;
		cw.fields.d31_26 = d[31:26];
		cw.fields.c32    = c[5];
		cw.fields.d25_11 = d[25:11];
		cw.fields.c16    = c[4];
		cw.fields.d10_4  = d[10:4];
		cw.fields.c8     = c[3];
		cw.fields.d3_1   = d[3:1];
		cw.fields.c4     = c[2];
		cw.fields.d0     = d[0];
		cw.fields.c2     = c[1];
		cw.fields.c1     = c[0];
		cw.fields.par    = c[6];
		return cw;
	endfunction

	assign access    = psel & penable & ~rd_pend;  // first access cycle only.
	assign mem_sel   = ~paddr[ilm_pkg::reg_sel_bit];
	assign aligned   = (paddr[1:0] == 2'b00);
	assign reg_off   = paddr[ilm_pkg::reg_sel_bit-1:0];
	assign word_addr = paddr[ilm_pkg::ilm_aw+1:2];

	assign mem_wr = access & mem_sel & aligned & pwrite;
	assign mem_rd = access & mem_sel & aligned & ~pwrite;
	assign reg_wr = access & ~mem_sel & pwrite;

	// check bits are the xor of the positions holding a one.
	always_comb begin
		ilm_pkg::ilm_codeword_u base;
		base = pack_cw(pwdata, '0);
		chk = '0;
		for (int k = 1; k < ilm_pkg::ilm_cw; k++) begin
			if (base.raw[k])
				chk = chk ^ k[ilm_pkg::ilm_pw-1:0];
		end
		enc = pack_cw(pwdata, {^{pwdata, chk}, chk});
	end

	assign inj = pack_cw(inj_data, inj_check);

	assign ram.cs    = mem_wr | mem_rd;
	assign ram.we    = mem_wr;
	assign ram.addr  = word_addr;
	assign ram.wdata = enc.raw ^ inj.raw;

	assign pready  = (access & ~mem_rd) | rd_pend;
	assign pslverr = rd_pend ? uncorr_err : (access & mem_sel & ~aligned);

	always_comb begin
		case (reg_off)
			ilm_pkg::reg_inj_data:  reg_rdata = inj_data;
			ilm_pkg::reg_inj_check: reg_rdata = {{(ilm_pkg::ilm_dw-ilm_pkg::ilm_pw-1){1'b0}},
			                                     inj_check};
			ilm_pkg::reg_corr_cnt:  reg_rdata = {{(ilm_pkg::ilm_dw-ilm_pkg::cnt_w){1'b0}},
			                                     corr_cnt};
			ilm_pkg::reg_ue_stat:   reg_rdata = {7'd0, ue_addr, 15'd0, ue_flag};
			default:                reg_rdata = '0;
		endcase
	end

	always_comb begin
		if (rd_pend)
			prdata = rdata_fix;
		else if (mem_sel)
			prdata = '0;  // misaligned memory access.
		else
			prdata = reg_rdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rd_pend <= 1'b0;
		else
			rd_pend <= mem_rd;
	end

	// masks corrupt exactly one memory write.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			inj_data  <= '0;
			inj_check <= '0;
		end else if (mem_wr) begin
			inj_data  <= '0;
			inj_check <= '0;
		end else if (reg_wr) begin
			if (reg_off == ilm_pkg::reg_inj_data)
				inj_data <= pwdata;
			if (reg_off == ilm_pkg::reg_inj_check)
				inj_check <= pwdata[ilm_pkg::ilm_pw:0];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			corr_cnt <= '0;
		else if (reg_wr && reg_off == ilm_pkg::reg_corr_cnt)
			corr_cnt <= '0;
		else if (rd_pend && corr_err && corr_cnt != '1)
			corr_cnt <= corr_cnt + 1'b1;  // saturates.
	end

	// paddr is still held by the master during the wait state.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ue_flag <= 1'b0;
			ue_addr <= '0;
		end else if (reg_wr && reg_off == ilm_pkg::reg_ue_stat) begin
			ue_flag <= 1'b0;
			ue_addr <= '0;
		end else if (rd_pend && uncorr_err) begin
			ue_flag <= 1'b1;
			ue_addr <= word_addr;
		end
	end

endmodule

`default_nettype wire

/* src/ilm_ecc_ram.sv */
// ILM ECC RAM wrapper, a 512 x 39 single port array with one cycle read latency.
`timescale 1ns/100ps
`default_nettype none

module ilm_ecc_ram (
	input wire     clk,
	ilm_ram_if.ram ram
);

	logic [ilm_pkg::ilm_cw-1:0] mem [0:(1<<ilm_pkg::ilm_aw)-1];

	// behavioral array in place of a vendor macro.
	always_ff @(posedge clk) begin
		if (ram.cs && ram.we)
			mem[ram.addr] <= ram.wdata.raw;
	end

	// rdata only moves on a read, so it holds across writes.
	always_ff @(posedge clk) begin
		if (ram.cs && !ram.we)
			ram.rdata.raw <= mem[ram.addr];
	end

endmodule

`default_nettype wire

/* src/ilm_ecc_decode.sv */
// ILM SECDED decoder that corrects single bit errors and flags double bit errors.
`timescale 1ns/100ps
`default_nettype none

module ilm_ecc_decode (
	input  wire ilm_pkg::ilm_codeword_u  cw,
	output logic [ilm_pkg::ilm_dw-1:0]   rdata_fix,
	output logic                         corr_err,
	output logic                         uncorr_err
);

	logic [ilm_pkg::ilm_pw-1:0] syn;
	logic                       syn_hit;
	logic                       syn_ok;   // points inside the codeword.
	logic                       par_bad;
	ilm_pkg::ilm_codeword_u     fixed;

	// syndrome is the xor of the positions holding a one.
	always_comb begin
		syn = '0;
		for (int k = 1; k < ilm_pkg::ilm_cw; k++) begin
			if (cw.raw[k])
				syn = syn ^ k[ilm_pkg::ilm_pw-1:0];
		end
	end

	assign par_bad = ^cw.raw;
	assign syn_hit = (syn != '0);
	assign syn_ok  = (syn < ilm_pkg::ilm_cw);

	// bad parity means an odd count of flips, taken as one.
	// a zero syndrome then blames the parity bit itself.
	assign corr_err   = par_bad & syn_ok;
	assign uncorr_err = (syn_hit & ~par_bad) | (par_bad & ~syn_ok);

	always_comb begin
		fixed = cw;
		if (corr_err && syn_hit)
			fixed.raw[syn] = ~cw.raw[syn];
	end

	assign rdata_fix = {
		fixed.fields.d31_26,
		fixed.fields.d25_11,
		fixed.fields.d10_4,
		fixed.fields.d3_1,
		fixed.fields.d0
	};

endmodule

`default_nettype wire

/* src/ilm_ecc_top.sv */
// ILM ECC top level joining the APB slave, the ECC RAM and the SECDED decoder.
`timescale 1ns/100ps
`default_nettype none

module ilm_ecc_top (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        psel,
	input  wire                        penable,
	input  wire                        pwrite,
	input  wire [ilm_pkg::apb_aw-1:0]  paddr,
	input  wire [ilm_pkg::ilm_dw-1:0]  pwdata,
	output wire [ilm_pkg::ilm_dw-1:0]  prdata,
	output wire                        pready,
	output wire                        pslverr
);

	logic [ilm_pkg::ilm_dw-1:0] rdata_fix;
	logic                       corr_err;
	logic                       uncorr_err;

	ilm_ram_if ram_bus ();

	ilm_apb_slave u_slave (
		.clk        (clk),
		.arst_n     (arst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.ram        (ram_bus.master),
		.rdata_fix  (rdata_fix),
		.corr_err   (corr_err),
		.uncorr_err (uncorr_err)
	);

	ilm_ecc_ram u_ram (
		.clk (clk),
		.ram (ram_bus.ram)
	);

	// decoder works on the registered ram output.
	ilm_ecc_decode u_dec (
		.cw         (ram_bus.rdata),
		.rdata_fix  (rdata_fix),
		.corr_err   (corr_err),
		.uncorr_err (uncorr_err)
	);

endmodule

`default_nettype wire

/* testbench/tb_ilm_ecc.sv */
// ILM ECC testbench running directed APB tests against the SECDED instruction memory.
`timescale 1ns/100ps
`default_nettype none

module tb_ilm_ecc;

	localparam int n_xfers   = 100;  // upper bound on transfers over all tests.
	localparam int wd_cycles = n_xfers * 4 + 200;

	logic                        clk;
	logic                        arst_n;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [ilm_pkg::apb_aw-1:0]  paddr;
	logic [ilm_pkg::ilm_dw-1:0]  pwdata;
	wire  [ilm_pkg::ilm_dw-1:0]  prdata;
	wire                         pready;
	wire                         pslverr;

	integer      seed = 32'h9cea220d;
	int          errors = 0;
	int          checks = 0;
	int          tests_ok = 0;
	int          tests_bad = 0;
	int          exp_cnt = 0;      // corrected count the design should hold.
	logic [31:0] model [0:511];    // last data written per word.

	ilm_ecc_top u_dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic logic [15:0] mem_addr(input logic [8:0] word);
		return {5'd0, word, 2'b00};
	endfunction

	function automatic logic [15:0] reg_addr(input logic [11:0] off);
		return {4'h1, off};  // bit 12 picks the register window.
	endfunction

	function automatic logic [8:0] rand_word();
		return $unsigned($random(seed)) % 512;
	endfunction

	// one APB transfer, sampled mid cycle where outputs are settled.
	task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
	                        output logic [31:0] rdata, output logic err, output int waits);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waits = 0;
		@(negedge clk);
		while (!pready) begin
			waits++;
			@(negedge clk);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] rd;
		int          waits;
		apb_xfer(1'b1, addr, data, rd, err, waits);
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err,
	                        output int waits);
		apb_xfer(1'b0, addr, 32'd0, data, err, waits);
	endtask

	task automatic write_reg(input logic [11:0] off, input logic [31:0] data);
		logic err;
		apb_write(reg_addr(off), data, err);
		check("pslverr", err, 1'b0);
	endtask

	task automatic read_reg(input logic [11:0] off, output logic [31:0] data);
		logic err;
		int   waits;
		apb_read(reg_addr(off), data, err, waits);
		check("pslverr", err, 1'b0);
		check("reg read waits", waits, 0);  // no wait state in the register window.
	endtask

	task automatic write_word(input logic [8:0] word, input logic [31:0] data);
		logic err;
		model[word] = data;
		apb_write(mem_addr(word), data, err);
		check("pslverr", err, 1'b0);
	endtask

	task automatic verify_word(input logic [8:0] word);
		logic [31:0] rd;
		logic        err;
		int          waits;
		apb_read(mem_addr(word), rd, err, waits);
		check("prdata", rd, model[word]);
		check("pslverr", err, 1'b0);
		check("mem read waits", waits, 1);
	endtask

	task automatic count_is();
		logic [31:0] rd;
		read_reg(ilm_pkg::reg_corr_cnt, rd);
		check("corr_cnt", rd, exp_cnt);
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			tests_ok++;
			$display("test %s: passed", name);
		end else begin
			tests_bad++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic clean_rw();
		logic [8:0]  words [16];
		logic [31:0] rd;
		for (int i = 0; i < 16; i++) begin
			words[i] = rand_word();
			write_word(words[i], $random(seed));
		end
		for (int i = 0; i < 16; i++)
			verify_word(words[i]);
		count_is();
		read_reg(ilm_pkg::reg_ue_stat, rd);
		check("ue_stat", rd, 32'd0);
	endtask

	task automatic data_bit_fix();
		logic [8:0] word;
		int         bit_n;
		word  = rand_word();
		bit_n = $unsigned($random(seed)) % 32;
		write_reg(ilm_pkg::reg_inj_data, 32'd1 << bit_n);
		write_word(word, $random(seed));
		verify_word(word);
		exp_cnt++;
		count_is();
		verify_word(word);  // flip stays in the array.
		exp_cnt++;
		count_is();
	endtask

	task automatic check_bit_fix();
		logic [8:0] word;
		for (int i = 0; i < 7; i++) begin
			word = rand_word();
			write_reg(ilm_pkg::reg_inj_check, 32'd1 << i);
			write_word(word, $random(seed));
			verify_word(word);
			exp_cnt++;
			count_is();
		end
	endtask

	task automatic double_error();
		logic [8:0]  word;
		logic [31:0] rd;
		logic        err;
		int          waits;
		int          b0;
		int          b1;
		for (int round = 0; round < 2; round++) begin
			word = rand_word();
			b0   = $unsigned($random(seed)) % 32;
			if (round == 0) begin
				b1 = (b0 + 1 + $unsigned($random(seed)) % 31) % 32;  // distinct bit.
				write_reg(ilm_pkg::reg_inj_data, (32'd1 << b0) | (32'd1 << b1));
			end else begin
				write_reg(ilm_pkg::reg_inj_data, 32'd1 << b0);
				write_reg(ilm_pkg::reg_inj_check, 32'd1 << ($unsigned($random(seed)) % 7));
			end
			write_word(word, $random(seed));
			apb_read(mem_addr(word), rd, err, waits);
			check("pslverr", err, 1'b1);
			count_is();
			read_reg(ilm_pkg::reg_ue_stat, rd);
			check("ue_stat", rd, {7'd0, word, 15'd0, 1'b1});
		end
	endtask

	task automatic inject_clear();
		logic [8:0]  word_a;
		logic [8:0]  word_b;
		logic [31:0] rd;
		word_a = rand_word();
		word_b = word_a + 9'd1;
		write_reg(ilm_pkg::reg_inj_data, 32'd1 << 3);
		write_word(word_a, $random(seed));
		read_reg(ilm_pkg::reg_inj_data, rd);
		check("inj_data", rd, 32'd0);
		write_word(word_b, $random(seed));
		verify_word(word_b);
		count_is();
		write_reg(ilm_pkg::reg_corr_cnt, 32'hffff_ffff);
		write_reg(ilm_pkg::reg_ue_stat, 32'hffff_ffff);
		exp_cnt = 0;
		count_is();
		read_reg(ilm_pkg::reg_ue_stat, rd);
		check("ue_stat", rd, 32'd0);
	endtask

	initial begin
		int err_before;
		arst_n  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (16) @(posedge clk);
		#1 arst_n = 1'b1;

		err_before = errors;
		clean_rw();
		report_test("clean write/read", err_before);
		err_before = errors;
		data_bit_fix();
		report_test("single data bit", err_before);
		err_before = errors;
		check_bit_fix();
		report_test("single check bit", err_before);
		err_before = errors;
		double_error();
		report_test("double error", err_before);
		err_before = errors;
		inject_clear();
		report_test("self clear and register clear", err_before);

		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
		         tests_ok, tests_bad, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// ends a hung run.
	initial begin
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, transfers never completed", wd_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
src/ilm_pkg.sv
src/ilm_ram_if.sv
src/ilm_apb_slave.sv
src/ilm_ecc_ram.sv
src/ilm_ecc_decode.sv
src/ilm_ecc_top.sv
testbench/tb_ilm_ecc.sv
